//--- tb.f
hdl/win_pkg.sv
hdl/line_buffer.sv
hdl/window_datapath.sv
hdl/window_sum.sv
hdl/stream_ctrl.sv
hdl/box_filter_top.sv
dv/clk_gen.sv
dv/tb_box_filter.sv

//--- run.sh
#!/bin/sh
# build and run the box filter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_box_filter -o sim_box_filter || exit 1

out=$(./obj_dir/sim_box_filter)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Finished with no errors" && exit 0 || exit 1

//--- dv/tb_box_filter.sv
`timescale 1ns/100ps
`default_nettype none

module tb_box_filter;

  import win_pkg::*;

  localparam int COLS         = 16;
  localparam int ROWS         = 16;
  localparam int FRAMES       = 2;
  localparam int OUT_COLS     = COLS - WIN + 1;
  localparam int PER_FRAME    = OUT_COLS * (ROWS - WIN + 1);
  localparam int TOTAL_RES    = FRAMES * PER_FRAME;
  localparam int TOTAL_PIX    = FRAMES * COLS * ROWS;
  localparam int MAX_ACK_DLY  = 7;   // 3 random bits
  localparam int DRAIN_CYC    = 40;
  // about 4 cycles per pixel, plus a full output handshake per pixel as worst case
  localparam int WATCHDOG_CYC = TOTAL_PIX * (MAX_ACK_DLY + 16) + 500;

  logic    clk;
  logic    rst_n;
  logic    pix_req;
  pixel_t  pix_data;
  logic    pix_ack;
  logic    res_req;
  result_t res;
  logic    res_ack;

  pixel_t      img [FRAMES][COLS*ROWS];  // model copy of every frame
  logic [31:0] lfsr_q = 32'h9743;
  int          n_results = 0;
  int          n_accepted = 0;
  int          value_errs = 0;
  int          proto_errs = 0;
  logic        rst_low_q = 1'b0;
  logic        ack_q = 1'b0;

  clk_gen #(.PERIOD(100), .RST_CYCLES(8)) clkgen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  box_filter_top #(.COLS(COLS), .ROWS(ROWS)) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_req_i  (pix_req),
    .pix_data_i (pix_data),
    .pix_ack_o  (pix_ack),
    .res_req_o  (res_req),
    .res_o      (res),
    .res_ack_i  (res_ack)
  );

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic int block_sum(input int f, input int x, input int y);
    int s;
    s = 0;
    for (int r = 0; r < WIN; r++) begin
      for (int c = 0; c < WIN; c++) begin
        s += int'(img[f][(y + r) * COLS + x + c]);
      end
    end
    return s;
  endfunction

  task automatic report_mismatch(input string msg);
    value_errs++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  task automatic send_pixel(input pixel_t p);
    pix_req  <= 1'b1;
    pix_data <= p;
    do @(posedge clk); while (!pix_ack);
    pix_req <= 1'b0;
    do @(posedge clk); while (pix_ack);
  endtask

  task automatic check_result(input result_t r);
    int f;
    int pos;
    int ex;
    int ey;
    int exp_sum;
    if (n_results >= TOTAL_RES) begin
      proto_errs++;
      $display("extra result at %0t beyond the last frame, x %0d y %0d", $time, r.x, r.y);
    end else begin
      f       = n_results / PER_FRAME;
      pos     = n_results % PER_FRAME;
      ex      = pos % OUT_COLS;  // raster order
      ey      = pos / OUT_COLS;
      exp_sum = block_sum(f, ex, ey);
      assert (int'(r.x) == ex && int'(r.y) == ey) else
        report_mismatch($sformatf("result %0d at x %0d y %0d, expected x %0d y %0d",
                                  n_results, r.x, r.y, ex, ey));
      assert (r.last == (pos == PER_FRAME - 1)) else
        report_mismatch($sformatf("result %0d last flag %0b", n_results, r.last));
      assert (int'(r.sum) == exp_sum) else
        report_mismatch($sformatf("frame %0d x %0d y %0d sum %0d, expected %0d",
                                  f, ex, ey, r.sum, exp_sum));
    end
    n_results++;
  endtask

  // reset state, plus a count of accepted pixels
  always @(posedge clk) begin
    rst_low_q <= !rst_n;
    if (rst_low_q) begin
      assert (!pix_ack && !res_req) else
        report_mismatch($sformatf("ack %0b req %0b in reset", pix_ack, res_req));
    end
    ack_q <= pix_ack;
    if (pix_ack && !ack_q) begin
      n_accepted++;
    end
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    (!pix_req && !pix_ack) |=> !pix_ack)
    else begin
      proto_errs++;
      $display("pixel ack rose without a request at %0t", $time);
    end

  a_ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (pix_req && pix_ack) |=> pix_ack)
    else begin
      proto_errs++;
      $display("pixel ack fell while the request was still high at %0t", $time);
    end

  a_ack_falls: assert property (@(posedge clk) disable iff (!rst_n)
    (!pix_req && pix_ack) |=> !pix_ack)
    else begin
      proto_errs++;
      $display("pixel ack stayed high after the request fell at %0t", $time);
    end

  // input stalls while a result is handed over
  a_pix_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (res_req || res_ack) |=> !$rose(pix_ack))
    else begin
      proto_errs++;
      $display("pixel accepted during a result handshake at %0t", $time);
    end

  a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (res_req && !res_ack) |=> (res_req && $stable(res)))
    else begin
      proto_errs++;
      $display("result request or data changed before ack at %0t", $time);
    end

  a_res_wait_ack: assert property (@(posedge clk) disable iff (!rst_n)
    (!res_req && res_ack) |=> !res_req)
    else begin
      proto_errs++;
      $display("new result request raised while ack was still high at %0t", $time);
    end

  // result receiver with random ack delay
  initial begin : receiver
    result_t got;
    int      dly;
    res_ack <= 1'b0;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      if (res_req) begin
        got = res;
        check_result(got);
        dly = int'(rand_bits(3));
        repeat (dly) @(posedge clk);
        res_ack <= 1'b1;
        do @(posedge clk); while (res_req);
        res_ack <= 1'b0;
      end
    end
  end

  initial begin : stimulus
    pix_req  <= 1'b0;
    pix_data <= '0;
    for (int f = 0; f < FRAMES; f++) begin
      for (int i = 0; i < COLS * ROWS; i++) begin
        img[f][i] = pixel_t'(rand_bits(8));
      end
    end
    wait (rst_n === 1'b1);
    @(posedge clk);
    // both frames back to back
    for (int f = 0; f < FRAMES; f++) begin
      for (int i = 0; i < COLS * ROWS; i++) begin
        send_pixel(img[f][i]);
      end
    end
    while (n_results < TOTAL_RES) @(posedge clk);
    repeat (DRAIN_CYC) @(posedge clk);  // room for a stray result
    assert (n_results == TOTAL_RES) else
      report_mismatch($sformatf("%0d results, expected %0d", n_results, TOTAL_RES));
    $display("results %0d/%0d, pixels %0d/%0d, value errors %0d, protocol errors %0d",
             n_results, TOTAL_RES, n_accepted, TOTAL_PIX, value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("timeout after %0d cycles, %0d of %0d results and %0d of %0d pixels seen",
             WATCHDOG_CYC, n_results, TOTAL_RES, n_accepted, TOTAL_PIX);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD     = 100,  // ns
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // released on a rising edge, like any other input
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- hdl/box_filter_top.sv
`timescale 1ns/100ps
`default_nettype none

module box_filter_top #(
  parameter int COLS = 16,
  parameter int ROWS = 16
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               pix_req_i,
  input  wire win_pkg::pixel_t    pix_data_i,
  output logic                    pix_ack_o,
  output logic                    res_req_o,
  output win_pkg::result_t        res_o,
  input  wire logic               res_ack_i
);

  import win_pkg::*;

  logic             shift_en;
  column_t          col;
  window_t          win;
  logic             win_valid;
  logic [POS_W-1:0] win_x;
  logic [POS_W-1:0] win_y;
  logic             frame_last;
  logic             sum_valid;
  result_t          res;

  stream_ctrl ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_req_i   (pix_req_i),
    .pix_ack_o   (pix_ack_o),
    .shift_en_o  (shift_en),
    .win_valid_i (win_valid),
    .sum_valid_i (sum_valid),
    .res_i       (res),
    .res_req_o   (res_req_o),
    .res_o       (res_o),
    .res_ack_i   (res_ack_i)
  );

  line_buffer #(.COLS(COLS)) lbuf_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_en_i (shift_en),
    .pix_i      (pix_data_i),
    .col_o      (col)
  );

  window_datapath #(.COLS(COLS), .ROWS(ROWS)) wdp_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .shift_en_i   (shift_en),
    .col_i        (col),
    .win_o        (win),
    .win_valid_o  (win_valid),
    .win_x_o      (win_x),
    .win_y_o      (win_y),
    .frame_last_o (frame_last)
  );

  window_sum sum_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .win_i   (win),
    .valid_i (win_valid),
    .x_i     (win_x),
    .y_i     (win_y),
    .last_i  (frame_last),
    .valid_o (sum_valid),
    .res_o   (res)
  );

endmodule

`default_nettype wire

//--- hdl/stream_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module stream_ctrl (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               pix_req_i,
  output logic                    pix_ack_o,
  output logic                    shift_en_o,
  input  wire logic               win_valid_i,
  input  wire logic               sum_valid_i,
  input  wire win_pkg::result_t   res_i,
  output logic                    res_req_o,
  output win_pkg::result_t        res_o,
  input  wire logic               res_ack_i
);

  logic [1:0] inflight_q;  // windows not yet through the output handshake
  logic       res_wait_q;  // req dropped, ack still high
  logic       res_done;

  // win_valid_i lands one cycle after the shift, while ack is still high
  assign shift_en_o = pix_req_i && !pix_ack_o && (inflight_q == 2'd0);
  assign res_done   = res_wait_q && !res_ack_i;

  // input handshake
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_ack_o <= 1'b0;
    end else if (shift_en_o) begin
      pix_ack_o <= 1'b1;
    end else if (!pix_req_i) begin
      pix_ack_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inflight_q <= 2'd0;
    end else begin
      inflight_q <= inflight_q + {1'b0, win_valid_i} - {1'b0, res_done};
    end
  end

  // output handshake
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_req_o  <= 1'b0;
      res_wait_q <= 1'b0;
    end else begin
      if (sum_valid_i) begin
        res_req_o <= 1'b1;
      end else if (res_req_o && res_ack_i) begin
        res_req_o <= 1'b0;
      end
      if (res_req_o && res_ack_i) begin
        res_wait_q <= 1'b1;
      end else if (!res_ack_i) begin
        res_wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid_i) begin
      res_o <= res_i;  // held for the whole handshake
    end
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(pix_ack_o) |-> $past(pix_req_i));

  // req and data stay put until the receiver answers
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (res_req_o && !res_ack_i) |=> (res_req_o && $stable(res_o)));

endmodule

`default_nettype wire

//--- hdl/window_sum.sv
`timescale 1ns/100ps
`default_nettype none

module window_sum (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire win_pkg::window_t      win_i,
  input  wire logic                  valid_i,
  input  wire logic [win_pkg::POS_W-1:0] x_i,
  input  wire logic [win_pkg::POS_W-1:0] y_i,
  input  wire logic                  last_i,
  output logic                       valid_o,
  output win_pkg::result_t           res_o
);

  import win_pkg::*;

  logic [SUM_W-1:0] col_sum [WIN];
  logic [SUM_W-1:0] col_sum_q [WIN];
  logic [SUM_W-1:0] total;
  logic             v1_q;
  logic [POS_W-1:0] x1_q;
  logic [POS_W-1:0] y1_q;
  logic             last1_q;

  // stage 1, one 13-input adder per column
  always_comb begin
    for (int c = 0; c < WIN; c++) begin
      col_sum[c] = '0;
      for (int r = 0; r < WIN; r++) begin
        col_sum[c] = col_sum[c] + SUM_W'(win_i.col[c].px[r]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      col_sum_q <= col_sum;
      x1_q      <= x_i;
      y1_q      <= y_i;
      last1_q   <= last_i;
    end
  end

  // stage 2
  always_comb begin
    total = '0;
    for (int c = 0; c < WIN; c++) begin
      total = total + col_sum_q[c];
    end
  end

  always_ff @(posedge clk) begin
    if (v1_q) begin
      res_o.sum  <= total;
      res_o.x    <= x1_q;
      res_o.y    <= y1_q;
      res_o.last <= last1_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v1_q    <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      v1_q    <= valid_i;
      valid_o <= v1_q;
    end
  end

endmodule

`default_nettype wire

//--- hdl/window_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module window_datapath #(
  parameter int COLS = 16,
  parameter int ROWS = 16
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  shift_en_i,
  input  wire win_pkg::column_t      col_i,
  output win_pkg::window_t           win_o,
  output logic                       win_valid_o,
  output logic [win_pkg::POS_W-1:0]  win_x_o,
  output logic [win_pkg::POS_W-1:0]  win_y_o,
  output logic                       frame_last_o
);

  import win_pkg::*;

  logic [POS_W-1:0] x_cnt;  // position of the pixel now at the input
  logic [POS_W-1:0] y_cnt;
  logic             x_wrap;
  logic             y_wrap;
  logic             full;

  assign x_wrap = (x_cnt == POS_W'(COLS - 1));
  assign y_wrap = (y_cnt == POS_W'(ROWS - 1));
  // this shift completes a 13x13 block inside the image
  assign full   = (x_cnt >= POS_W'(WIN - 1)) && (y_cnt >= POS_W'(WIN - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (shift_en_i) begin
      if (x_wrap) begin
        x_cnt <= '0;
        y_cnt <= y_wrap ? '0 : y_cnt + 1'b1;
      end else begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  // newest column enters at the top index
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_o <= '0;
    end else if (shift_en_i) begin
      win_o.col[WIN-1] <= col_i;
      for (int i = 0; i < WIN - 1; i++) begin
        win_o.col[i] <= win_o.col[i+1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid_o  <= 1'b0;
      win_x_o      <= '0;
      win_y_o      <= '0;
      frame_last_o <= 1'b0;
    end else begin
      win_valid_o <= shift_en_i && full;
      if (shift_en_i) begin
        win_x_o      <= x_cnt - POS_W'(WIN - 1);  // left edge
        win_y_o      <= y_cnt - POS_W'(WIN - 1);
        frame_last_o <= x_wrap && y_wrap;
      end
    end
  end

  // counters never leave the image
  a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
    (x_cnt < POS_W'(COLS)) && (y_cnt < POS_W'(ROWS)));

  // the input handshake keeps shifts at least two cycles apart
  a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    win_valid_o |=> !win_valid_o);

endmodule

`default_nettype wire

//--- hdl/line_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module line_buffer #(
  parameter int COLS = 16
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              shift_en_i,
  input  wire win_pkg::pixel_t   pix_i,
  output win_pkg::column_t       col_o
);

  import win_pkg::*;

  localparam int TAPS = WIN - 1;  // rows held above the live pixel

  pixel_t line_q [TAPS][COLS];
  pixel_t line_in [TAPS];

  // each delay line is fed from the tail of the previous one
  always_comb begin
    line_in[0] = pix_i;
    for (int k = 1; k < TAPS; k++) begin
      line_in[k] = line_q[k-1][COLS-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < TAPS; k++) begin
        for (int j = 0; j < COLS; j++) begin
          line_q[k][j] <= '0;
        end
      end
    end else if (shift_en_i) begin
      for (int k = 0; k < TAPS; k++) begin
        line_q[k][0] <= line_in[k];
        for (int j = 1; j < COLS; j++) begin
          line_q[k][j] <= line_q[k][j-1];
        end
      end
    end
  end

  // tail of line k is k+1 rows above the live pixel
  always_comb begin
    col_o.px[WIN-1] = pix_i;
    for (int k = 0; k < TAPS; k++) begin
      col_o.px[WIN-2-k] = line_q[k][COLS-1];
    end
  end

endmodule

`default_nettype wire

//--- hdl/win_pkg.sv
`default_nettype none

package win_pkg;

  localparam int WIN   = 13;  // window edge, fixed
  localparam int SUM_W = 16;  // 169 * 255 fits
  localparam int POS_W = 10;

  typedef logic [7:0] pixel_t;

  // one vertical slice
  // px[0] is the oldest row, px[WIN-1] the live one
  typedef struct packed {
    pixel_t [WIN-1:0] px;
  } column_t;

  // col[0] is the oldest column
  typedef struct packed {
    column_t [WIN-1:0] col;
  } window_t;

  typedef struct packed {
    logic [SUM_W-1:0] sum;
    logic [POS_W-1:0] x;     // left column of the window
    logic [POS_W-1:0] y;     // top row
    logic             last;  // bottom-right window of the frame
  } result_t;

endpackage

`default_nettype wire
